// ==== verilog.f ====
design/poly_pkg.sv
design/core_memory.sv
design/residue_alu.sv
design/memory_group.sv
design/poly_sequencer.sv
design/poly_proc_top.sv
bench/poly_proc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= poly_proc_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/poly_proc_tb.sv ====
`timescale 1ns/1ps

module poly_proc_tb import poly_pkg::*; ();

    localparam int POLY_LEN  = 16;
    localparam int NUM_CASES = 6;

    // Load, two full readbacks and the run of one case
    localparam int CASE_CYCLES = 2 * POLY_LEN * NUM_CORES
                               + 2 * NUM_BANKS * NUM_CORES * POLY_LEN
                               + POLY_LEN + 8;
    localparam int CYCLE_LIMIT = 2 * (NUM_CASES * CASE_CYCLES + 10);

    // Residue primes per modulus set and core
    localparam logic [COEFF_W-1:0] PRIMES [2][NUM_CORES] = '{
        '{30'd1073741789, 30'd1073741783, 30'd1073741741, 30'd1073741723,
          30'd1073741719, 30'd1073741717, 30'd1073741689},
        '{30'd1004535809, 30'd998244353, 30'd985661441, 30'd962592769,
          30'd950009857, 30'd943718401, 30'd754974721}
    };

    typedef struct packed {
        opcode_e           op;
        logic              sel;
        logic [BANK_W-1:0] src_a;
        logic [BANK_W-1:0] src_b;
        logic [BANK_W-1:0] dst;
        logic              bcast;
        logic              wrap;
    } case_t;

    logic        clk;
    logic        rst_n;
    op_cmd_t     op_cmd;
    logic        modulus_sel;
    host_req_t   host_req;
    coeff_word_u host_rdata;
    logic        done;

    case_t             cases [NUM_CASES];
    logic [WORD_W-1:0] model [NUM_CORES][NUM_BANKS][POLY_LEN];
    logic              bank_known [NUM_BANKS];
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;
    int                seed;

    poly_proc_top #(
        .POLY_LEN (POLY_LEN)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_cmd      (op_cmd),
        .modulus_sel (modulus_sel),
        .host_req    (host_req),
        .host_rdata  (host_rdata),
        .done        (done)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    // Step to just past the next rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [COEFF_W-1:0] rand_below(input logic [COEFF_W-1:0] q);
        logic [31:0] r;
        r = $random(seed);
        return COEFF_W'(r % {2'b00, q});
    endfunction

    // Broadcast words must fit under every prime of the set
    function automatic logic [COEFF_W-1:0] lowest_prime(input logic sel);
        logic [COEFF_W-1:0] low;
        low = PRIMES[sel][0];
        for (int c = 1; c < NUM_CORES; c++) begin
            if (PRIMES[sel][c] < low) begin
                low = PRIMES[sel][c];
            end
        end
        return low;
    endfunction

    function automatic logic [COEFF_W-1:0] expect_lane(input opcode_e op,
                                                       input logic [COEFF_W-1:0] a,
                                                       input logic [COEFF_W-1:0] b,
                                                       input logic [COEFF_W-1:0] q);
        longint unsigned x;
        longint unsigned y;
        longint unsigned m;
        x = 64'(a);
        y = 64'(b);
        m = 64'(q);
        if (op == OP_ADD) begin
            return COEFF_W'((x + y) % m);
        end
        return COEFF_W'((x + m - y) % m);
    endfunction

    task automatic host_write(input logic [CORE_W-1:0] core, input logic bcast,
                              input logic [BANK_W-1:0] bank, input logic [ADDR_W-1:0] addr,
                              input logic [WORD_W-1:0] word);
        host_req.en        = 1'b1;
        host_req.we        = 1'b1;
        host_req.broadcast = bcast;
        host_req.core      = core;
        host_req.bank      = bank;
        host_req.addr      = addr;
        host_req.data.raw  = word;
        tick();
        host_req.en = 1'b0;
        host_req.we = 1'b0;
    endtask

    task automatic host_read(input logic [CORE_W-1:0] core, input logic [BANK_W-1:0] bank,
                             input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] word);
        host_req.en        = 1'b1;
        host_req.we        = 1'b0;
        host_req.broadcast = 1'b0;
        host_req.core      = core;
        host_req.bank      = bank;
        host_req.addr      = addr;
        tick();
        word        = host_rdata.raw;
        host_req.en = 1'b0;
    endtask

    task automatic check_done(input logic exp);
        checks++;
        assert (done === exp) else begin
            $display("[ERROR] done got %h expected %h", done, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Case steps
    ////////////////////////////////////////
    task automatic load_case(input case_t tc);
        logic [COEFF_W-1:0] q;
        logic [COEFF_W-1:0] lane [4];
        logic [COEFF_W-1:0] tmp;
        logic [WORD_W-1:0]  wa;
        logic [WORD_W-1:0]  wb;
        int                 cores;
        cores = tc.bcast ? 1 : NUM_CORES;
        for (int k = 0; k < POLY_LEN; k++) begin
            for (int c = 0; c < cores; c++) begin
                q = tc.bcast ? lowest_prime(tc.sel) : PRIMES[tc.sel][c];
                for (int i = 0; i < 4; i++) begin
                    lane[i] = rand_below(q);
                end
                // Even addresses get a < b in both lanes
                if (tc.wrap && (k % 2 == 0)) begin
                    for (int i = 0; i < 2; i++) begin
                        if (lane[i] > lane[i+2]) begin
                            tmp       = lane[i];
                            lane[i]   = lane[i+2];
                            lane[i+2] = tmp;
                        end
                    end
                end
                wa = {lane[0], lane[1]};
                wb = {lane[2], lane[3]};
                host_write(CORE_W'(c), tc.bcast, tc.src_a, ADDR_W'(k), wa);
                host_write(CORE_W'(c), tc.bcast, tc.src_b, ADDR_W'(k), wb);
                for (int m = 0; m < NUM_CORES; m++) begin
                    if (tc.bcast || m == c) begin
                        model[m][tc.src_a][k] = wa;
                        model[m][tc.src_b][k] = wb;
                    end
                end
            end
        end
        bank_known[tc.src_a] = 1'b1;
        bank_known[tc.src_b] = 1'b1;
    endtask

    // Every written bank of every core against the model
    task automatic verify_memory();
        logic [WORD_W-1:0] got;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_known[b]) begin
                for (int c = 0; c < NUM_CORES; c++) begin
                    for (int k = 0; k < POLY_LEN; k++) begin
                        host_read(CORE_W'(c), BANK_W'(b), ADDR_W'(k), got);
                        checks++;
                        assert (got == model[c][b][k]) else begin
                            $display("[ERROR] host_rdata core %0d bank %0d addr %0d got %h expected %h",
                                     c, b, k, got, model[c][b][k]);
                            errors++;
                        end
                    end
                end
            end
        end
    endtask

    task automatic run_case(input case_t tc);
        int n;
        check_done(1'b0);
        op_cmd.opcode = tc.op;
        op_cmd.src_a  = tc.src_a;
        op_cmd.src_b  = tc.src_b;
        op_cmd.dst    = tc.dst;
        modulus_sel   = tc.sel;
        n = 0;
        while (done !== 1'b1) begin
            tick();
            n++;
        end
        checks++;
        assert (n == POLY_LEN + 2) else begin
            $display("[ERROR] done latency got %h expected %h", n, POLY_LEN + 2);
            errors++;
        end
        tick();
        check_done(1'b1);
        op_cmd.opcode = OP_IDLE;
        tick();
        check_done(1'b0);
    endtask

    task automatic apply_model(input case_t tc);
        logic [WORD_W-1:0]  a;
        logic [WORD_W-1:0]  b;
        logic [COEFF_W-1:0] q;
        for (int c = 0; c < NUM_CORES; c++) begin
            q = PRIMES[tc.sel][c];
            for (int k = 0; k < POLY_LEN; k++) begin
                a = model[c][tc.src_a][k];
                b = model[c][tc.src_b][k];
                model[c][tc.dst][k] = {expect_lane(tc.op, a[WORD_W-1:COEFF_W],
                                                   b[WORD_W-1:COEFF_W], q),
                                       expect_lane(tc.op, a[COEFF_W-1:0], b[COEFF_W-1:0], q)};
            end
        end
        bank_known[tc.dst] = 1'b1;
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        op_cmd      = '0;
        modulus_sel = 1'b0;
        host_req    = '0;
        seed        = 32'he080213f;
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_known[b] = 1'b0;
        end

        // op, sel, src_a, src_b, dst, broadcast, force a < b
        cases[0] = '{OP_ADD, 1'b0, 2'd0, 2'd1, 2'd2, 1'b0, 1'b0};
        cases[1] = '{OP_ADD, 1'b1, 2'd0, 2'd1, 2'd3, 1'b1, 1'b0};
        cases[2] = '{OP_SUB, 1'b0, 2'd1, 2'd2, 2'd3, 1'b0, 1'b1};
        cases[3] = '{OP_SUB, 1'b1, 2'd2, 2'd3, 2'd0, 1'b1, 1'b1};
        cases[4] = '{OP_ADD, 1'b1, 2'd1, 2'd3, 2'd1, 1'b0, 1'b0};
        cases[5] = '{OP_SUB, 1'b0, 2'd3, 2'd0, 2'd3, 1'b0, 1'b1};

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_done(1'b0);

        for (int n = 0; n < NUM_CASES; n++) begin
            load_case(cases[n]);
            verify_memory();
            run_case(cases[n]);
            apply_model(cases[n]);
            verify_memory();
        end

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== design/poly_proc_top.sv ====
`timescale 1ns/1ps

module poly_proc_top import poly_pkg::*; #(
    parameter int POLY_LEN = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  op_cmd_t     op_cmd,
    input  logic        modulus_sel,
    input  host_req_t   host_req,
    output coeff_word_u host_rdata,
    output logic        done
);

    eng_rd_t     eng_rd;
    eng_wr_t     eng_wr;
    logic        alu_valid;
    opcode_e     alu_op;
    core_words_t rd_a;
    core_words_t rd_b;
    core_words_t wr_data;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////
    poly_sequencer #(
        .POLY_LEN (POLY_LEN)
    ) u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_cmd    (op_cmd),
        .eng_rd    (eng_rd),
        .eng_wr    (eng_wr),
        .alu_valid (alu_valid),
        .alu_op    (alu_op),
        .done      (done)
    );

    ////////////////////////////////////////
    // Coefficient memories
    ////////////////////////////////////////
    memory_group u_mem (
        .clk        (clk),
        .host_req   (host_req),
        .eng_rd     (eng_rd),
        .eng_wr     (eng_wr),
        .wr_data    (wr_data),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .host_rdata (host_rdata),
        .busy       (alu_op != OP_IDLE)
    );

    ////////////////////////////////////////
    // One ALU per residue core
    ////////////////////////////////////////
    for (genvar i = 0; i < NUM_CORES; i++) begin : g_alu
        residue_alu #(
            .CORE_ID (i)
        ) u_alu (
            .clk         (clk),
            .rst_n       (rst_n),
            .modulus_sel (modulus_sel),
            .op          (alu_op),
            .valid       (alu_valid),
            .a           (rd_a[i]),
            .b           (rd_b[i]),
            .y           (wr_data[i])
        );
    end

endmodule

// ==== design/poly_sequencer.sv ====
`timescale 1ns/1ps

module poly_sequencer import poly_pkg::*; #(
    parameter int POLY_LEN = 16
) (
    input  logic    clk,
    input  logic    rst_n,
    input  op_cmd_t op_cmd,
    output eng_rd_t eng_rd,
    output eng_wr_t eng_wr,
    output logic    alu_valid,
    output opcode_e alu_op,
    output logic    done
);

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(POLY_LEN - 1);

    logic              busy;
    logic              rd_fire;
    logic              rd_done;
    logic [ADDR_W-1:0] rd_addr;
    logic              s1_valid;
    logic              s2_valid;
    logic [ADDR_W-1:0] s1_addr;
    logic [ADDR_W-1:0] s2_addr;

    if (POLY_LEN > (1 << ADDR_W) || POLY_LEN < 1) begin : g_len_check
        $error("poly_sequencer POLY_LEN %0d does not fit the bank depth", POLY_LEN);
    end

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////
    assign busy    = (op_cmd.opcode != OP_IDLE);
    assign alu_op  = op_cmd.opcode;
    assign rd_fire = busy && !rd_done;

    ////////////////////////////////////////
    // Read address counter
    ////////////////////////////////////////
    // Parked at address 0 while idle, so cycle 0 reads address 0
    always_ff @(posedge clk) begin
        if (!rst_n || !busy) begin
            rd_addr <= '0;
            rd_done <= 1'b0;
        end else if (rd_fire) begin
            if (rd_addr == LAST_ADDR) begin
                rd_done <= 1'b1;
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Pipeline tracking and done
    ////////////////////////////////////////
    // Stage 1 is memory data at the ALU, stage 2 is ALU result at memory
    always_ff @(posedge clk) begin
        if (!rst_n || !busy) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= rd_fire;
            s2_valid <= s1_valid;
            if (s2_valid && (s2_addr == LAST_ADDR)) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= rd_addr;
        s2_addr <= s1_addr;
    end

    assign alu_valid = s1_valid;

    always_comb begin
        eng_rd.addr   = rd_addr;
        eng_rd.bank_a = op_cmd.src_a;
        eng_rd.bank_b = op_cmd.src_b;
        eng_wr.en     = s2_valid;
        eng_wr.addr   = s2_addr;
        eng_wr.bank   = op_cmd.dst;
    end

    // Opcode must stay up until the last write has gone out
    a_no_write_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !eng_wr.en)
        else $error("poly_sequencer write enable %b with idle opcode", eng_wr.en);

endmodule

// ==== design/memory_group.sv ====
`timescale 1ns/1ps

module memory_group import poly_pkg::*; (
    input  logic        clk,
    input  host_req_t   host_req,
    input  eng_rd_t     eng_rd,
    input  eng_wr_t     eng_wr,
    input  core_words_t wr_data,
    output core_words_t rd_a,
    output core_words_t rd_b,
    output coeff_word_u host_rdata,
    input  logic        busy
);

    logic [NUM_CORES-1:0] core_we;
    logic [BANK_W-1:0]    wr_bank;
    logic [ADDR_W-1:0]    wr_addr;
    logic [BANK_W-1:0]    rd_bank_a;
    logic [ADDR_W-1:0]    rd_addr;
    logic [CORE_W-1:0]    host_core_q;

    ////////////////////////////////////////
    // Host over engine muxing
    ////////////////////////////////////////
    assign wr_bank   = host_req.en ? host_req.bank : eng_wr.bank;
    assign wr_addr   = host_req.en ? host_req.addr : eng_wr.addr;
    assign rd_bank_a = host_req.en ? host_req.bank : eng_rd.bank_a;
    assign rd_addr   = host_req.en ? host_req.addr : eng_rd.addr;

    // Broadcast turns on every core
    always_comb begin
        for (int c = 0; c < NUM_CORES; c++) begin
            if (host_req.en) begin
                core_we[c] = host_req.we &&
                             (host_req.broadcast || (host_req.core == CORE_W'(c)));
            end else begin
                core_we[c] = eng_wr.en;
            end
        end
    end

    for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
        coeff_word_u wr_word;

        assign wr_word = host_req.en ? host_req.data : wr_data[c];

        core_memory u_mem (
            .clk       (clk),
            .we        (core_we[c]),
            .wr_bank   (wr_bank),
            .wr_addr   (wr_addr),
            .wr_word   (wr_word),
            .rd_bank_a (rd_bank_a),
            .rd_bank_b (eng_rd.bank_b),
            .rd_addr   (rd_addr),
            .rd_word_a (rd_a[c]),
            .rd_word_b (rd_b[c])
        );
    end

    ////////////////////////////////////////
    // Host readback
    ////////////////////////////////////////
    // Core select follows the read data by one cycle
    always_ff @(posedge clk) begin
        if (host_req.en) begin
            host_core_q <= host_req.core;
        end
    end

    assign host_rdata = (host_core_q < CORE_W'(NUM_CORES)) ? rd_a[host_core_q] : '0;

    // Host traffic during a running operation would corrupt the engine
    a_no_host_while_busy: assert property (@(posedge clk) !(host_req.en && busy))
        else $error("memory_group host access while operation running");

endmodule

// ==== design/residue_alu.sv ====
`timescale 1ns/1ps

module residue_alu import poly_pkg::*; #(
    parameter int CORE_ID = 0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        modulus_sel,
    input  opcode_e     op,
    input  logic        valid,
    input  coeff_word_u a,
    input  coeff_word_u b,
    output coeff_word_u y
);

    logic [COEFF_W-1:0] q;

    // One lane of modular add or subtract
    function automatic logic [COEFF_W-1:0] lane_op(input opcode_e     lop,
                                                   input logic [COEFF_W-1:0] x,
                                                   input logic [COEFF_W-1:0] z,
                                                   input logic [COEFF_W-1:0] m);
        logic [COEFF_W:0] sum;
        logic [COEFF_W:0] diff;
        logic [COEFF_W:0] red;
        sum  = {1'b0, x} + {1'b0, z};
        diff = {1'b0, x} - {1'b0, z};
        red  = sum - {1'b0, m};
        if (lop == OP_SUB) begin
            // Borrow out means a < b, fold back by adding q
            return diff[COEFF_W] ? diff[COEFF_W-1:0] + m : diff[COEFF_W-1:0];
        end
        return (sum >= {1'b0, m}) ? red[COEFF_W-1:0] : sum[COEFF_W-1:0];
    endfunction

    assign q = modulus_of(CORE_W'(CORE_ID), modulus_sel);

    always_ff @(posedge clk) begin
        if (valid) begin
            y.pair.hi <= lane_op(op, a.pair.hi, b.pair.hi, q);
            y.pair.lo <= lane_op(op, a.pair.lo, b.pair.lo, q);
        end
    end

    // Operands coming out of memory must already be reduced
    a_inputs_reduced: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> (a.pair.hi < q) && (a.pair.lo < q) && (b.pair.hi < q) && (b.pair.lo < q))
        else $error("residue_alu %0d operand not below modulus %h", CORE_ID, q);

endmodule

// ==== design/core_memory.sv ====
`timescale 1ns/1ps

module core_memory import poly_pkg::*; (
    input  logic              clk,
    input  logic              we,
    input  logic [BANK_W-1:0] wr_bank,
    input  logic [ADDR_W-1:0] wr_addr,
    input  coeff_word_u       wr_word,
    input  logic [BANK_W-1:0] rd_bank_a,
    input  logic [BANK_W-1:0] rd_bank_b,
    input  logic [ADDR_W-1:0] rd_addr,
    output coeff_word_u       rd_word_a,
    output coeff_word_u       rd_word_b
);

    localparam int DEPTH = 1 << ADDR_W;

    // Banks of one residue core
    coeff_word_u mem [NUM_BANKS][DEPTH];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_bank][wr_addr] <= wr_word;
        end
    end

    ////////////////////////////////////////
    // Read pair with one cycle latency
    ////////////////////////////////////////
    // Both banks chosen independently at the same address
    always_ff @(posedge clk) begin
        rd_word_a <= mem[rd_bank_a][rd_addr];
        rd_word_b <= mem[rd_bank_b][rd_addr];
    end

endmodule

// ==== design/poly_pkg.sv ====
package poly_pkg;

    ////////////////////////////////////////
    // Word geometry
    ////////////////////////////////////////
    localparam int COEFF_W   = 30;
    localparam int WORD_W    = 60;
    localparam int NUM_CORES = 7;
    localparam int NUM_BANKS = 4;
    localparam int BANK_W    = 2;
    localparam int ADDR_W    = 6;
    localparam int CORE_W    = 3;

    // Instruction codes where zero keeps the engine idle
    typedef enum logic [7:0] {
        OP_IDLE = 8'd0,
        OP_ADD  = 8'd1,
        OP_SUB  = 8'd2
    } opcode_e;

    typedef struct packed {
        logic [COEFF_W-1:0] hi;
        logic [COEFF_W-1:0] lo;
    } coeff_pair_t;

    // Host sees raw words, ALUs see coefficient pairs
    typedef union packed {
        logic [WORD_W-1:0] raw;
        coeff_pair_t       pair;
    } coeff_word_u;

    typedef coeff_word_u [NUM_CORES-1:0] core_words_t;

    typedef struct packed {
        opcode_e           opcode;
        logic [BANK_W-1:0] src_a;
        logic [BANK_W-1:0] src_b;
        logic [BANK_W-1:0] dst;
    } op_cmd_t;

    typedef struct packed {
        logic              en;
        logic              broadcast;
        logic              we;
        logic [CORE_W-1:0] core;
        logic [BANK_W-1:0] bank;
        logic [ADDR_W-1:0] addr;
        coeff_word_u       data;
    } host_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [BANK_W-1:0] bank_a;
        logic [BANK_W-1:0] bank_b;
    } eng_rd_t;

    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        logic [BANK_W-1:0] bank;
    } eng_wr_t;

    ////////////////////////////////////////
    // Modulus table
    ////////////////////////////////////////
    // Set 0 sits just under 2^30, set 1 holds NTT-friendly primes
    function automatic logic [COEFF_W-1:0] modulus_of(input logic [CORE_W-1:0] core,
                                                      input logic sel);
        case ({sel, core})
            4'h0:    return 30'd1073741789;
            4'h1:    return 30'd1073741783;
            4'h2:    return 30'd1073741741;
            4'h3:    return 30'd1073741723;
            4'h4:    return 30'd1073741719;
            4'h5:    return 30'd1073741717;
            4'h6:    return 30'd1073741689;
            4'h8:    return 30'd1004535809;
            4'h9:    return 30'd998244353;
            4'ha:    return 30'd985661441;
            4'hb:    return 30'd962592769;
            4'hc:    return 30'd950009857;
            4'hd:    return 30'd943718401;
            4'he:    return 30'd754974721;
            // Core index 7 does not exist
            default: return 30'd1073741789;
        endcase
    endfunction

endpackage
